// ==== rtl/fp_consts.svh ====
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// Number format
`define FP_EXP_W  8
`define FP_MAN_W  7
`define FP_WORD_W 16
`define FP_BIAS   127

// Host register map
`define FP_ADDR_W   2
`define FP_REG_A    2'd0
`define FP_REG_B    2'd1
`define FP_REG_CTRL 2'd2

`endif

// ==== rtl/fp_pkg.sv ====
`include "fp_consts.svh"

package fp_pkg;

    // One packed value: sign, exponent, stored mantissa
    typedef logic [`FP_WORD_W-1:0] fp_word_t;

    typedef logic [`FP_EXP_W-1:0] fp_exp_t;

    typedef logic [`FP_MAN_W-1:0] fp_man_t;

    // Stored mantissa with the hidden one on top
    typedef logic [`FP_MAN_W:0] fp_sig_t;

    typedef logic [`FP_ADDR_W-1:0] fp_addr_t;

    typedef enum logic {
        FP_ADD  = 1'b0,
        FP_MULT = 1'b1
    } fp_opcode_e;

endpackage

// ==== rtl/fp_operand_if.sv ====
`timescale 1ns/1ps

interface fp_operand_if;

    fp_pkg::fp_word_t   a;
    fp_pkg::fp_word_t   b;
    fp_pkg::fp_opcode_e op;
    logic               start;

    modport regs (
        output a,
        output b,
        output op,
        output start
    );

    modport pipe (
        input a,
        input b,
        input op,
        input start
    );

endinterface

// ==== rtl/fpu.sv ====
`timescale 1ns/1ps
`include "fp_consts.svh"

module fpu #(
    parameter fp_pkg::fp_opcode_e op = fp_pkg::FP_ADD
) (
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    output fp_pkg::fp_word_t result
);

    logic            sign_a;
    logic            sign_b;
    fp_pkg::fp_exp_t exp_a;
    fp_pkg::fp_exp_t exp_b;
    fp_pkg::fp_sig_t sig_a;
    fp_pkg::fp_sig_t sig_b;

    // Field split, hidden one restored
    assign sign_a = a[`FP_WORD_W-1];
    assign sign_b = b[`FP_WORD_W-1];
    assign exp_a  = a[`FP_WORD_W-2 -: `FP_EXP_W];
    assign exp_b  = b[`FP_WORD_W-2 -: `FP_EXP_W];
    assign sig_a  = {1'b1, a[`FP_MAN_W-1:0]};
    assign sig_b  = {1'b1, b[`FP_MAN_W-1:0]};

    if (op == fp_pkg::FP_MULT) begin : g_mul
        localparam logic [`FP_EXP_W+1:0] bias_ext = `FP_BIAS;

        logic [2*`FP_MAN_W+1:0] prod;
        logic                   norm;
        fp_pkg::fp_man_t        man_r;
        logic [`FP_EXP_W+1:0]   exp_sum;

        always_comb begin
            prod = sig_a * sig_b;
            norm = prod[2*`FP_MAN_W+1];
            if (norm) begin
                man_r = prod[2*`FP_MAN_W:`FP_MAN_W+1];
            end else begin
                man_r = prod[2*`FP_MAN_W-1:`FP_MAN_W];
            end
            // Rebias once, overflow not detected
            exp_sum = {2'b00, exp_a} + {2'b00, exp_b} + {{(`FP_EXP_W+1){1'b0}}, norm}
                      - bias_ext;
            result = {sign_a ^ sign_b, exp_sum[`FP_EXP_W-1:0], man_r};
        end
    end else begin : g_add
        fp_pkg::fp_sig_t      al_a;
        fp_pkg::fp_sig_t      al_b;
        fp_pkg::fp_exp_t      exp_big;
        logic [`FP_MAN_W+1:0] sum;
        logic                 sign_r;
        fp_pkg::fp_exp_t      exp_r;
        fp_pkg::fp_man_t      man_r;
        logic                 found;

        always_comb begin
            // Align to the larger exponent
            if (exp_a >= exp_b) begin
                al_a    = sig_a;
                al_b    = sig_b >> (exp_a - exp_b);
                exp_big = exp_a;
            end else begin
                al_a    = sig_a >> (exp_b - exp_a);
                al_b    = sig_b;
                exp_big = exp_b;
            end

            if (sign_a == sign_b) begin
                sum    = {1'b0, al_a} + {1'b0, al_b};
                sign_r = sign_a;
            end else if (al_a >= al_b) begin
                sum    = {1'b0, al_a} - {1'b0, al_b};
                sign_r = sign_a;
            end else begin
                sum    = {1'b0, al_b} - {1'b0, al_a};
                sign_r = sign_b;
            end

            found = 1'b0;
            exp_r = exp_big;
            man_r = '0;
            if (sum[`FP_MAN_W+1]) begin
                exp_r = exp_big + 1'b1;
                man_r = sum[`FP_MAN_W:1];
            end else begin
                // Leading one search
                for (int i = 0; i <= `FP_MAN_W; i++) begin
                    if (!found && sum[`FP_MAN_W-i]) begin
                        found = 1'b1;
                        exp_r = exp_big - fp_pkg::fp_exp_t'(i);
                        man_r = fp_pkg::fp_man_t'(sum << i);
                    end
                end
            end

            // Exact cancellation gives plain zero
            if (sum == '0) begin
                result = '0;
            end else begin
                result = {sign_r, exp_r, man_r};
            end
        end
    end

endmodule

// ==== rtl/fp_regfile.sv ====
`timescale 1ns/1ps
`include "fp_consts.svh"

module fp_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  fp_pkg::fp_addr_t wr_addr,
    input  fp_pkg::fp_word_t wr_data,
    input  logic             start,
    fp_operand_if.regs       ops
);

    fp_pkg::fp_word_t   a_q;
    fp_pkg::fp_word_t   b_q;
    fp_pkg::fp_opcode_e op_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q  <= '0;
            b_q  <= '0;
            op_q <= fp_pkg::FP_ADD;
        end else if (wr_en) begin
            case (wr_addr)
                `FP_REG_A: begin
                    a_q <= wr_data;
                end
                `FP_REG_B: begin
                    b_q <= wr_data;
                end
                `FP_REG_CTRL: begin
                    op_q <= wr_data[0] ? fp_pkg::FP_MULT : fp_pkg::FP_ADD;
                end
                default: begin
                    // Address 3 unused
                end
            endcase
        end
    end

    assign ops.a  = a_q;
    assign ops.b  = b_q;
    assign ops.op = op_q;

    // Pipeline samples start at the same edge
    assign ops.start = start;

endmodule

// ==== rtl/fp_exec_pipe.sv ====
`timescale 1ns/1ps

module fp_exec_pipe (
    input  logic             clk,
    input  logic             rst_n,
    fp_operand_if.pipe       ops,
    output fp_pkg::fp_word_t result,
    output logic             done
);

    fp_pkg::fp_word_t   s1_a;
    fp_pkg::fp_word_t   s1_b;
    fp_pkg::fp_opcode_e s1_op;
    logic               s1_valid;
    fp_pkg::fp_word_t   add_res;
    fp_pkg::fp_word_t   mul_res;
    fp_pkg::fp_word_t   sel_res;

    // Stage 1 control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_op    <= fp_pkg::FP_ADD;
        end else begin
            s1_valid <= ops.start;
            if (ops.start) begin
                s1_op <= ops.op;
            end
        end
    end

    // Stage 1 operands
    always_ff @(posedge clk) begin
        if (ops.start) begin
            s1_a <= ops.a;
            s1_b <= ops.b;
        end
    end

    fpu #(.op(fp_pkg::FP_ADD)) u_add (
        .a      (s1_a),
        .b      (s1_b),
        .result (add_res)
    );

    fpu #(.op(fp_pkg::FP_MULT)) u_mul (
        .a      (s1_a),
        .b      (s1_b),
        .result (mul_res)
    );

    assign sel_res = (s1_op == fp_pkg::FP_MULT) ? mul_res : add_res;

    // Stage 2, result holds until the next operation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= s1_valid;
            if (s1_valid) begin
                result <= sel_res;
            end
        end
    end

endmodule

// ==== rtl/fp_coproc_top.sv ====
`timescale 1ns/1ps

module fp_coproc_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  fp_pkg::fp_addr_t wr_addr,
    input  fp_pkg::fp_word_t wr_data,
    input  logic             start,
    output fp_pkg::fp_word_t result,
    output logic             done
);

    fp_operand_if ops_if ();

    // Host registers
    fp_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .start   (start),
        .ops     (ops_if.regs)
    );

    // Two-cycle execute
    fp_exec_pipe u_exec_pipe (
        .clk    (clk),
        .rst_n  (rst_n),
        .ops    (ops_if.pipe),
        .result (result),
        .done   (done)
    );

endmodule

// ==== tb/fp_coproc_props.sv ====
`timescale 1ns/1ps

module fp_coproc_props (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done
);

    // Fixed two-cycle latency
    a_done_after_start: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> ##2 done
    ) else $error("done missing two edges after start");

    a_no_spurious_done: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> $past(start, 2)
    ) else $error("done without a start two edges before");

    a_done_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> !done
    ) else $error("done high during reset");

endmodule

bind fp_exec_pipe fp_coproc_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .start (ops.start),
    .done  (done)
);

// ==== tb/fp_coproc_tb.sv ====
`timescale 1ns/1ps
`include "fp_consts.svh"

module fp_coproc_tb;

    localparam int MAX_CYCLES = 400;

    logic             clk;
    logic             rst_n;
    logic             wr_en;
    fp_pkg::fp_addr_t wr_addr;
    fp_pkg::fp_word_t wr_data;
    logic             start;
    fp_pkg::fp_word_t result;
    logic             done;

    int                 cycle;
    logic [15:0]        exp_res[$];
    int                 exp_cyc[$];
    string              exp_lbl[$];
    logic [15:0]        shadow_a;
    logic [15:0]        shadow_b;
    fp_pkg::fp_opcode_e shadow_op;

    fp_coproc_top fp_coproc_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .start   (start),
        .result  (result),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Tests need roughly 110 cycles
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string msg);
        if (got !== want) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, got, want);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    // Add and multiply rules with truncation
    function automatic logic [15:0] expected_result(input logic [15:0] a, input logic [15:0] b,
                                                    input fp_pkg::fp_opcode_e op);
        int   ea;
        int   eb;
        int   ma;
        int   mb;
        int   e;
        int   sum;
        int   prod;
        logic s;
        ea = {24'd0, a[14:7]};
        eb = {24'd0, b[14:7]};
        ma = {24'd0, 1'b1, a[6:0]};
        mb = {24'd0, 1'b1, b[6:0]};
        if (op == fp_pkg::FP_MULT) begin
            prod = ma * mb;
            s    = a[15] ^ b[15];
            if (prod[15]) begin
                e = ea + eb - `FP_BIAS + 1;
                return {s, e[7:0], prod[14:8]};
            end
            e = ea + eb - `FP_BIAS;
            return {s, e[7:0], prod[13:7]};
        end
        if (ea >= eb) begin
            e  = ea;
            mb = mb >> (ea - eb);
        end else begin
            e  = eb;
            ma = ma >> (eb - ea);
        end
        if (a[15] == b[15]) begin
            sum = ma + mb;
            s   = a[15];
        end else if (ma >= mb) begin
            sum = ma - mb;
            s   = a[15];
        end else begin
            sum = mb - ma;
            s   = b[15];
        end
        if (sum == 0) begin
            return 16'h0000;
        end
        if (sum >= 256) begin
            sum = sum >> 1;
            e   = e + 1;
        end
        while (sum < 128) begin
            sum = sum * 2;
            e   = e - 1;
        end
        return {s, e[7:0], sum[6:0]};
    endfunction

    function automatic logic [15:0] random_operand();
        logic [7:0] e;
        logic [6:0] m;
        logic       s;
        s = 1'($urandom_range(1, 0));
        e = 8'($urandom_range(190, 64));
        m = 7'($urandom_range(127, 0));
        return {s, e, m};
    endfunction

    // Expected value comes from the registers before this edge
    task automatic drive_cycle(input logic we, input fp_pkg::fp_addr_t addr,
                               input logic [15:0] data, input logic go, input string label);
        @(posedge clk);
        #2;
        wr_en   = we;
        wr_addr = addr;
        wr_data = data;
        start   = go;
        if (go) begin
            exp_res.push_back(expected_result(shadow_a, shadow_b, shadow_op));
            exp_cyc.push_back(cycle + 2);
            exp_lbl.push_back(label);
        end
        if (we && addr == `FP_REG_A) begin
            shadow_a = data;
        end else if (we && addr == `FP_REG_B) begin
            shadow_b = data;
        end else if (we && addr == `FP_REG_CTRL) begin
            shadow_op = data[0] ? fp_pkg::FP_MULT : fp_pkg::FP_ADD;
        end
    endtask

    task automatic wait_drain();
        while (exp_res.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin : result_monitor
        string       lbl;
        logic [15:0] want;
        int          when;
        if (rst_n && done) begin
            if (exp_res.size() == 0) begin
                $display("done was raised at %0t with no operation in flight", $time);
                $display("** FAIL **");
                $fatal(1, "unexpected done");
            end else begin
                lbl  = exp_lbl.pop_front();
                want = exp_res.pop_front();
                when = exp_cyc.pop_front();
                check(cycle, when, {lbl, " done cycle"});
                check({16'd0, result}, {16'd0, want}, lbl);
            end
        end
    end

    task automatic run_op(input logic [15:0] a, input logic [15:0] b,
                          input fp_pkg::fp_opcode_e op, input string label);
        drive_cycle(1'b1, `FP_REG_A, a, 1'b0, label);
        drive_cycle(1'b1, `FP_REG_B, b, 1'b0, label);
        drive_cycle(1'b1, `FP_REG_CTRL, {15'd0, op == fp_pkg::FP_MULT}, 1'b0, label);
        drive_cycle(1'b0, `FP_REG_A, 16'h0000, 1'b1, label);
        drive_cycle(1'b0, `FP_REG_A, 16'h0000, 1'b0, label);
        wait_drain();
    endtask

    task automatic test_reset_state();
        repeat (6) begin
            @(negedge clk);
            check({16'd0, result}, 32'd0, "result after reset");
            check({31'd0, done}, 32'd0, "done after reset");
        end
    endtask

    task automatic test_add_same_sign();
        run_op(16'h3FC0, 16'h3EA0, fp_pkg::FP_ADD, "add aligned");
        run_op(16'h3FC0, 16'h3FA0, fp_pkg::FP_ADD, "add carry out");
        run_op(16'hBFC0, 16'hC040, fp_pkg::FP_ADD, "add both negative");
    endtask

    task automatic test_add_opposite_sign();
        run_op(16'h3F80, 16'hC040, fp_pkg::FP_ADD, "sub larger b");
        run_op(16'h4010, 16'hC000, fp_pkg::FP_ADD, "sub normalize");
        run_op(16'h3FC0, 16'hBFC0, fp_pkg::FP_ADD, "sub cancel");
    endtask

    task automatic test_multiply();
        run_op(16'h3FA0, 16'h3FA0, fp_pkg::FP_MULT, "mul no top bit");
        run_op(16'h3FC0, 16'h3FC0, fp_pkg::FP_MULT, "mul top bit");
        run_op(16'hC040, 16'h3EA0, fp_pkg::FP_MULT, "mul mixed sign");
    endtask

    // Start every cycle with one register write beside each start
    task automatic test_random_back_to_back();
        logic [15:0] d;
        drive_cycle(1'b1, `FP_REG_A, random_operand(), 1'b0, "random");
        drive_cycle(1'b1, `FP_REG_B, random_operand(), 1'b0, "random");
        for (int i = 0; i < 30; i++) begin
            if (i % 3 == 2) begin
                d = {15'd0, ~shadow_op};
                drive_cycle(1'b1, `FP_REG_CTRL, d, 1'b1, $sformatf("random op %0d", i));
            end else if (i % 3 == 1) begin
                drive_cycle(1'b1, `FP_REG_B, random_operand(), 1'b1,
                            $sformatf("random op %0d", i));
            end else begin
                drive_cycle(1'b1, `FP_REG_A, random_operand(), 1'b1,
                            $sformatf("random op %0d", i));
            end
        end
        drive_cycle(1'b0, `FP_REG_A, 16'h0000, 1'b0, "random");
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h7e4a6d19));
        cycle     = 0;
        rst_n     = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = `FP_REG_A;
        wr_data   = 16'h0000;
        start     = 1'b0;
        shadow_a  = 16'h0000;
        shadow_b  = 16'h0000;
        shadow_op = fp_pkg::FP_ADD;
        #1;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_add_same_sign();
        test_add_opposite_sign();
        test_multiply();
        test_random_back_to_back();
        // Idle cycles expose any late or extra done
        repeat (3) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/fp_pkg.sv
rtl/fp_operand_if.sv
rtl/fpu.sv
rtl/fp_regfile.sv
rtl/fp_exec_pipe.sv
rtl/fp_coproc_top.sv
tb/fp_coproc_props.sv
tb/fp_coproc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fp_coproc_tb \
    -f sources.f \
    -o fp_coproc_sim

./obj_dir/fp_coproc_sim
